//--- hdl/kd11_pkg.sv
`default_nettype none

package kd11_pkg;

	localparam int ADDR_W = 18;
	localparam int DATA_W = 16;

	// internal registers answer without a bus cycle
	localparam logic [ADDR_W-1:0] ADRS_PSW = 18'o777776;
	localparam logic [ADDR_W-1:0] ADRS_SLR = 18'o777774;

	// bus timing in clocks
	localparam int BUS_DESKEW = 2;
	localparam int BUS_TIMEOUT = 32;
	localparam int DSK_W = $clog2(BUS_DESKEW + 1);
	localparam int TMO_W = $clog2(BUS_TIMEOUT);

	// C1/C0 encoding
	typedef enum logic [1:0] {
		DATI = 2'b00,
		DATIP = 2'b01,
		DATO = 2'b10,
		DATOB = 2'b11
	} bus_cycle_e;

	typedef enum logic [1:0] {
		ERR_NONE = 2'b00,
		ERR_ODD = 2'b01,
		ERR_TIMEOUT = 2'b10
	} bus_err_e;

	typedef enum logic [1:0] {
		IDLE = 2'b00,
		REQ = 2'b01,
		WAIT = 2'b10
	} console_state_e;

	typedef struct packed {
		logic valid;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		bus_cycle_e cycle;
	} cycle_req_t;

	typedef struct packed {
		logic done;
		logic [DATA_W-1:0] data;
		bus_err_e err;
	} cycle_rsp_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] d;
		logic c1;
		logic c0;
		logic msyn;
	} unibus_out_t;

endpackage

`default_nettype wire

//--- hdl/ky11_console.sv
`default_nettype none
`timescale 1ns/10ps

module ky11_console import kd11_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic ldadrs_sw,
	input logic exam_sw,
	input logic dep_sw,
	input logic [ADDR_W-1:0] sr,
	input cycle_rsp_t rsp,
	output cycle_req_t req,
	output logic [DATA_W-1:0] data_lights,
	output logic [ADDR_W-1:0] addr_lights,
	output logic busy,
	output logic berr
);
	console_state_e state;
	logic [2:0] sw_s;
	logic [2:0] sw_d;
	logic [2:0] sw_rise;
	logic ld_edge;
	logic exam_edge;
	logic dep_edge;
	logic start_op;
	logic start_dep;
	logic prev_exam;
	logic prev_dep;
	logic [ADDR_W-1:0] adrs;
	logic [DATA_W-1:0] wdata;
	bus_cycle_e cycle;

	// rising edge seen one clock after the sample
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sw_s <= '0;
			sw_d <= '0;
		end else begin
			sw_s <= {ldadrs_sw, exam_sw, dep_sw};
			sw_d <= sw_s;
		end
	end

	assign sw_rise = sw_s & ~sw_d;
	assign ld_edge = sw_rise[2];
	assign exam_edge = sw_rise[1];
	assign dep_edge = sw_rise[0];

	// load address wins, then examine, then deposit
	assign start_op = (state == IDLE) && !ld_edge && (exam_edge || dep_edge);
	assign start_dep = start_op && !exam_edge;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			adrs <= '0;
			prev_exam <= 1'b0;
			prev_dep <= 1'b0;
			berr <= 1'b0;
			data_lights <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (ld_edge) begin
						adrs <= sr;
						prev_exam <= 1'b0;
						prev_dep <= 1'b0;
						berr <= 1'b0;
					end else if (start_op) begin
						// same operation again steps to the next word
						if ((start_dep && prev_dep) || (!start_dep && prev_exam))
							adrs <= adrs + ADDR_W'(2);
						prev_exam <= !start_dep;
						prev_dep <= start_dep;
						berr <= 1'b0;
						state <= REQ;
					end
				end
				REQ: state <= WAIT;
				WAIT: begin
					if (rsp.done) begin
						berr <= rsp.err != ERR_NONE;
						data_lights <= (cycle == DATO) ? wdata : rsp.data;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_op) begin
			wdata <= sr[DATA_W-1:0];
			cycle <= start_dep ? DATO : DATI;
		end
	end

	assign req.valid = state == REQ;
	assign req.addr = adrs;
	assign req.data = wdata;
	assign req.cycle = cycle;

	assign addr_lights = adrs;
	assign busy = state != IDLE;

endmodule

`default_nettype wire

//--- hdl/unibus_master.sv
`default_nettype none
`timescale 1ns/10ps

module unibus_master import kd11_pkg::*; (
	input logic clk,
	input logic rst_n,
	input cycle_req_t req,
	input logic [DATA_W-1:0] bus_d,
	input logic bus_ssyn,
	output unibus_out_t bus_out,
	output cycle_rsp_t rsp
);
	typedef enum logic [1:0] {
		M_IDLE,
		M_DESKEW,
		M_MSYN,
		M_END
	} mstate_e;

	mstate_e state;
	logic [DSK_W-1:0] dsk_cnt;
	logic [TMO_W-1:0] tmo_cnt;
	logic msyn_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] d_q;
	logic [1:0] cyc_q;
	logic [DATA_W-1:0] rd_data;
	logic internal;
	logic odd;
	logic rd_start;
	logic start;

	assign internal = (req.addr == ADRS_PSW) || (req.addr == ADRS_SLR);
	// only byte cycles may use an odd address
	assign odd = req.addr[0] && (req.cycle != DATOB);
	assign rd_start = req.cycle inside {DATI, DATIP};
	assign start = (state == M_IDLE) && req.valid && !internal && !odd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= M_IDLE;
			dsk_cnt <= '0;
			tmo_cnt <= '0;
			msyn_q <= 1'b0;
			rsp <= '0;
		end else begin
			rsp <= '0;
			case (state)
				M_IDLE: begin
					if (req.valid && !internal && odd) begin
						rsp.done <= 1'b1;
						rsp.err <= ERR_ODD;
					end else if (start) begin
						dsk_cnt <= '0;
						state <= M_DESKEW;
					end
				end
				M_DESKEW: begin
					dsk_cnt <= dsk_cnt + 1'b1;
					if (dsk_cnt == DSK_W'(BUS_DESKEW - 1)) begin
						msyn_q <= 1'b1;
						tmo_cnt <= '0;
						state <= M_MSYN;
					end
				end
				M_MSYN: begin
					if (bus_ssyn) begin
						msyn_q <= 1'b0;
						state <= M_END;
					end else if (tmo_cnt == TMO_W'(BUS_TIMEOUT - 1)) begin
						// no slave at this address
						msyn_q <= 1'b0;
						rsp.done <= 1'b1;
						rsp.err <= ERR_TIMEOUT;
						state <= M_IDLE;
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
				M_END: begin
					if (!bus_ssyn) begin
						rsp.done <= 1'b1;
						rsp.data <= cyc_q[1] ? '0 : rd_data;
						state <= M_IDLE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			addr_q <= req.addr;
			cyc_q <= req.cycle;
			d_q <= rd_start ? '0 : req.data;
		end
		if (state == M_MSYN && bus_ssyn && !cyc_q[1])
			rd_data <= bus_d;
	end

	assign bus_out.addr = addr_q;
	assign bus_out.d = d_q;
	assign bus_out.c1 = cyc_q[1];
	assign bus_out.c0 = cyc_q[0];
	assign bus_out.msyn = msyn_q;

endmodule

`default_nettype wire

//--- hdl/cpu_regs.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_regs import kd11_pkg::*; (
	input logic clk,
	input logic rst_n,
	input cycle_req_t req,
	output cycle_rsp_t rsp,
	output logic psw_user,
	output logic [4:0] flags
);
	logic [3:0] psw_hi;
	logic [7:0] psw_lo;
	logic [7:0] slr_hi;
	logic psw_sel;
	logic slr_sel;
	logic wr;
	logic wr_hi;
	logic [DATA_W-1:0] psw;
	logic [DATA_W-1:0] slr;

	assign psw_sel = req.valid && (req.addr == ADRS_PSW);
	assign slr_sel = req.valid && (req.addr == ADRS_SLR);
	assign wr = req.cycle inside {DATO, DATOB};
	// byte write at an even address leaves the high byte alone
	assign wr_hi = req.cycle == DATO;

	// unimplemented bits read zero
	assign psw = {psw_hi, 4'b0000, psw_lo};
	assign slr = {slr_hi, 8'h00};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			psw_hi <= '0;
			psw_lo <= '0;
			slr_hi <= '0;
			rsp <= '0;
		end else begin
			rsp <= '0;
			if (psw_sel || slr_sel) begin
				rsp.done <= 1'b1;
				rsp.err <= ERR_NONE;
				if (!wr)
					rsp.data <= psw_sel ? psw : slr;
			end
			if (psw_sel && wr) begin
				psw_lo <= req.data[7:0];
				if (wr_hi)
					psw_hi <= req.data[15:12];
			end
			if (slr_sel && wr_hi)
				slr_hi <= req.data[15:8];
		end
	end

	assign psw_user = psw_hi[3];
	assign flags = psw_lo[4:0];

endmodule

`default_nettype wire

//--- hdl/kd11_top.sv
`default_nettype none
`timescale 1ns/10ps

module kd11_top import kd11_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic ldadrs_sw,
	input logic exam_sw,
	input logic dep_sw,
	input logic [ADDR_W-1:0] sr,
	input logic [DATA_W-1:0] bus_d,
	input logic bus_ssyn,
	output unibus_out_t bus_out,
	output logic [DATA_W-1:0] data_lights,
	output logic [ADDR_W-1:0] addr_lights,
	output logic [2:0] status_lights,
	output logic [4:0] flags
);
	cycle_req_t req;
	cycle_rsp_t rsp;
	cycle_rsp_t rsp_bus;
	cycle_rsp_t rsp_regs;
	logic busy;
	logic berr;
	logic psw_user;

	// only one responder drives a nonzero response
	assign rsp = cycle_rsp_t'(rsp_bus | rsp_regs);

	// user, console, bus error
	assign status_lights = {psw_user, busy, berr};

	ky11_console ky11_console(
		.clk(clk),
		.rst_n(rst_n),
		.ldadrs_sw(ldadrs_sw),
		.exam_sw(exam_sw),
		.dep_sw(dep_sw),
		.sr(sr),
		.rsp(rsp),
		.req(req),
		.data_lights(data_lights),
		.addr_lights(addr_lights),
		.busy(busy),
		.berr(berr)
	);

	unibus_master unibus_master(
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.bus_d(bus_d),
		.bus_ssyn(bus_ssyn),
		.bus_out(bus_out),
		.rsp(rsp_bus)
	);

	cpu_regs cpu_regs(
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.rsp(rsp_regs),
		.psw_user(psw_user),
		.flags(flags)
	);

endmodule

`default_nettype wire

//--- tb/kd11_assert.sv
`default_nettype none
`timescale 1ns/10ps

module kd11_assert import kd11_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic msyn,
	input logic ssyn,
	input logic [ADDR_W-1:0] addr,
	input logic done
);

	// slave must be idle when a new cycle starts
	msyn_rise_idle: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(msyn) |-> !ssyn)
		else $error("MSYN rose while SSYN was high");

	addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		msyn |=> (!msyn || $stable(addr)))
		else $error("address changed while MSYN was high");

	done_after_msyn: assert property (@(posedge clk) disable iff (!rst_n)
		!(done && msyn))
		else $error("done pulsed with MSYN high");

endmodule

bind unibus_master kd11_assert kd11_assert(
	.clk(clk),
	.rst_n(rst_n),
	.msyn(bus_out.msyn),
	.ssyn(bus_ssyn),
	.addr(bus_out.addr),
	.done(rsp.done)
);

`default_nettype wire

//--- tb/tb_kd11.sv
`default_nettype none
`timescale 1ns/10ps

module tb_kd11 import kd11_pkg::*;;
	localparam int MEM_WORDS = 256;
	localparam int N_RANDOM = 300;
	localparam int WAIT_LIMIT = 200;

	typedef enum logic [1:0] {
		OP_LD,
		OP_EXAM,
		OP_DEP
	} op_e;

	logic clk;
	logic rst_n;
	logic ldadrs_sw;
	logic exam_sw;
	logic dep_sw;
	logic [ADDR_W-1:0] sr;
	logic [DATA_W-1:0] bus_d;
	logic bus_ssyn;
	unibus_out_t bus_out;
	logic [DATA_W-1:0] data_lights;
	logic [ADDR_W-1:0] addr_lights;
	logic [2:0] status_lights;
	logic [4:0] flags;

	logic [DATA_W-1:0] slave_mem [MEM_WORDS];
	logic [DATA_W-1:0] model_mem [MEM_WORDS];
	logic [ADDR_W-1:0] model_adrs;
	logic model_prev_exam;
	logic model_prev_dep;
	logic [DATA_W-1:0] model_psw;
	logic [DATA_W-1:0] model_slr;
	bus_cycle_e exp_cycle;
	integer seed;
	int errors;
	int checks;
	int slave_errors;
	int msyn_rises = 0;
	logic msyn_d = 1'b0;
	bit hung;
	string test_name;

	kd11_top dut(
		.clk(clk),
		.rst_n(rst_n),
		.ldadrs_sw(ldadrs_sw),
		.exam_sw(exam_sw),
		.dep_sw(dep_sw),
		.sr(sr),
		.bus_d(bus_d),
		.bus_ssyn(bus_ssyn),
		.bus_out(bus_out),
		.data_lights(data_lights),
		.addr_lights(addr_lights),
		.status_lights(status_lights),
		.flags(flags)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		if (bus_out.msyn && !msyn_d)
			msyn_rises <= msyn_rises + 1;
		msyn_d <= bus_out.msyn;
	end

	function automatic logic [DATA_W-1:0] fill_word(input int idx);
		logic [DATA_W-1:0] a;
		a = DATA_W'(idx * 2);
		return {a[7:0], a[15:8]} ^ (a * 16'h0ab5) ^ 16'hc3a5;
	endfunction

	function automatic logic in_window(input logic [ADDR_W-1:0] addr);
		return addr < ADDR_W'(MEM_WORDS * 2);
	endfunction

	function automatic int word_idx(input logic [ADDR_W-1:0] addr);
		return int'(addr >> 1);
	endfunction

	// memory slave on the Unibus
	initial begin : slave
		int lat;
		int n;
		int idx;
		bus_d = '0;
		bus_ssyn = 1'b0;
		slave_errors = 0;
		for (int i = 0; i < MEM_WORDS; i++)
			slave_mem[i] = fill_word(i);
		forever begin
			@(negedge clk);
			if (bus_out.msyn && !bus_ssyn && in_window(bus_out.addr)) begin
				idx = word_idx(bus_out.addr);
				check_val("bus cycle", 32'(exp_cycle), 32'({bus_out.c1, bus_out.c0}));
				lat = 1 + int'($unsigned($random(seed)) % 4);
				repeat (lat) @(negedge clk);
				if (bus_out.c1)
					slave_mem[idx] = bus_out.d;
				else
					bus_d = slave_mem[idx];
				bus_ssyn = 1'b1;
				n = 0;
				while (bus_out.msyn && n < WAIT_LIMIT) begin
					@(negedge clk);
					n++;
				end
				if (bus_out.msyn) begin
					$display("Error: MSYN stayed high after SSYN at address %o", bus_out.addr);
					slave_errors++;
				end
				bus_ssyn = 1'b0;
			end
		end
	end

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp == act) else begin
			$display("Error %s %s: expected %0o, actual %0o", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic compare_mem();
		int mism;
		mism = 0;
		for (int i = 0; i < MEM_WORDS; i++)
			if (slave_mem[i] !== model_mem[i])
				mism++;
		check_val("memory mismatches", 32'd0, 32'(mism));
	endtask

	// reference access at the model address
	task automatic model_access(input logic wr, input logic [DATA_W-1:0] wdata,
		output logic [DATA_W-1:0] rdata, output logic err, output logic no_bus);
		rdata = '0;
		err = 1'b0;
		no_bus = 1'b1;
		if (model_adrs == ADRS_PSW) begin
			if (wr)
				model_psw = wdata & 16'hf0ff;
			rdata = model_psw;
		end else if (model_adrs == ADRS_SLR) begin
			if (wr)
				model_slr = wdata & 16'hff00;
			rdata = model_slr;
		end else if (model_adrs[0]) begin
			err = 1'b1;
		end else if (in_window(model_adrs)) begin
			no_bus = 1'b0;
			if (wr)
				model_mem[word_idx(model_adrs)] = wdata;
			rdata = model_mem[word_idx(model_adrs)];
		end else begin
			no_bus = 1'b0;
			err = 1'b1;
		end
		if (wr)
			rdata = wdata;
	endtask

	task automatic do_op(input op_e op, input logic [ADDR_W-1:0] sw_val);
		int n;
		int rises;
		logic exp_berr;
		logic no_bus;
		logic [DATA_W-1:0] exp_data;
		exp_berr = 1'b0;
		no_bus = 1'b0;
		exp_data = '0;
		if (hung)
			return;
		if (op == OP_LD) begin
			model_adrs = sw_val;
			model_prev_exam = 1'b0;
			model_prev_dep = 1'b0;
		end else begin
			if ((op == OP_EXAM && model_prev_exam) || (op == OP_DEP && model_prev_dep))
				model_adrs = model_adrs + ADDR_W'(2);
			model_prev_exam = op == OP_EXAM;
			model_prev_dep = op == OP_DEP;
			model_access(op == OP_DEP, sw_val[DATA_W-1:0], exp_data, exp_berr, no_bus);
		end
		exp_cycle = (op == OP_DEP) ? DATO : DATI;
		rises = msyn_rises;
		sr = sw_val;
		ldadrs_sw = op == OP_LD;
		exam_sw = op == OP_EXAM;
		dep_sw = op == OP_DEP;
		@(negedge clk);
		ldadrs_sw = 1'b0;
		exam_sw = 1'b0;
		dep_sw = 1'b0;
		@(negedge clk);
		n = 0;
		while (status_lights[1] && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (status_lights[1]) begin
			$display("Error: console still busy after %0d cycles in %s", WAIT_LIMIT, test_name);
			errors++;
			hung = 1'b1;
			return;
		end
		check_val("address", 32'(model_adrs), 32'(addr_lights));
		check_val("bus error", 32'(exp_berr), 32'(status_lights[0]));
		if (op == OP_DEP || (op == OP_EXAM && !exp_berr))
			check_val("data", 32'(exp_data), 32'(data_lights));
		if (op != OP_LD)
			check_val("msyn rises", 32'(rises + (no_bus ? 0 : 1)), 32'(msyn_rises));
		check_val("flags", 32'(model_psw[4:0]), 32'(flags));
		check_val("user", 32'(model_psw[15]), 32'(status_lights[2]));
		if (op != OP_LD && model_adrs[0])
			compare_mem();
	endtask

	task automatic random_op();
		int pick;
		int cls;
		logic [ADDR_W-1:0] a;
		pick = int'($unsigned($random(seed)) % 10);
		cls = int'($unsigned($random(seed)) % 8);
		a = ADDR_W'(($unsigned($random(seed)) % MEM_WORDS) * 2);
		if (pick < 3) begin
			if (cls == 4)
				a = a | ADDR_W'(1);
			else if (cls == 5)
				a = ADRS_PSW;
			else if (cls == 6)
				a = ADRS_SLR;
			else if (cls == 7)
				a = a | 18'o400000;
			do_op(OP_LD, a);
		end else if (pick < 7) begin
			do_op(OP_EXAM, '0);
		end else begin
			do_op(OP_DEP, ADDR_W'($random(seed)));
		end
	endtask

	initial begin
		seed = 32'h38edda7f;
		clk = 1'b0;
		rst_n = 1'b0;
		ldadrs_sw = 1'b0;
		exam_sw = 1'b0;
		dep_sw = 1'b0;
		sr = '0;
		errors = 0;
		checks = 0;
		hung = 1'b0;
		exp_cycle = DATI;
		model_adrs = '0;
		model_prev_exam = 1'b0;
		model_prev_dep = 1'b0;
		model_psw = '0;
		model_slr = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = fill_word(i);
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		test_name = "load_examine";
		do_op(OP_LD, 18'o000100);
		do_op(OP_EXAM, '0);

		test_name = "deposit_step";
		do_op(OP_LD, 18'o000200);
		for (int i = 0; i < 4; i++)
			do_op(OP_DEP, ADDR_W'($random(seed)));
		do_op(OP_LD, 18'o000200);
		for (int i = 0; i < 4; i++)
			do_op(OP_EXAM, '0);

		test_name = "odd_address";
		do_op(OP_LD, 18'o000041);
		do_op(OP_EXAM, '0);
		do_op(OP_DEP, 18'o123456);

		// nothing answers up here
		test_name = "timeout";
		do_op(OP_LD, 18'o400000);
		do_op(OP_EXAM, '0);
		do_op(OP_LD, 18'o000100);

		test_name = "internal_regs";
		do_op(OP_LD, ADRS_PSW);
		do_op(OP_DEP, 18'o177777);
		do_op(OP_EXAM, '0);
		do_op(OP_DEP, 18'o100025);
		do_op(OP_EXAM, '0);
		do_op(OP_LD, ADRS_SLR);
		do_op(OP_DEP, 18'o012345);
		do_op(OP_EXAM, '0);

		test_name = "random";
		for (int i = 0; i < N_RANDOM; i++)
			random_op();

		test_name = "final_memory";
		compare_mem();

		errors = errors + slave_errors;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && !hung)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
hdl/kd11_pkg.sv
hdl/ky11_console.sv
hdl/unibus_master.sv
hdl/cpu_regs.sv
hdl/kd11_top.sv
tb/kd11_assert.sv
tb/tb_kd11.sv

//--- Makefile
TOP := tb_kd11

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
